// File: design/id_ex_pipe.sv
`timescale 1ns/1ps

module id_ex_pipe (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      instr_valid_i,
  input  id_pkg::word_t                             pc_i,
  input  id_pkg::decode_t                           dec_i,
  input  id_pkg::word_t                             jump_target_i,
  input  id_pkg::word_t [id_pkg::NUM_READ_PORTS-1:0] fwd_data_i,
  input  logic [id_pkg::NUM_READ_PORTS-1:0]         load_hazard_i,
  output logic                                      id_ready_o,
  output id_pkg::id_ex_t                            ex_o
);
  import id_pkg::*;

  logic   accept;
  id_ex_t ex_d;
  id_ex_t ex_q;

  // Any lane waiting on a load stalls the stage
  assign id_ready_o = ~|load_hazard_i;
  assign accept     = instr_valid_i && id_ready_o;

  ////////////////////
  // Operand select
  ////////////////////

  always_comb begin
    ex_d.pc        = pc_i;
    ex_d.rd        = dec_i.rd;
    ex_d.alu_op    = dec_i.alu_op;
    ex_d.illegal   = dec_i.illegal;
    ex_d.rd_we     = dec_i.rd_we;
    ex_d.mem_req   = dec_i.mem_req;
    ex_d.mem_we    = dec_i.mem_we;
    ex_d.is_load   = dec_i.is_load;
    ex_d.is_branch = dec_i.is_branch;
    ex_d.valid     = 1'b1;

    case (dec_i.op_a_sel)
      OP_A_PC:   ex_d.op_a = pc_i;
      OP_A_ZERO: ex_d.op_a = '0;
      default:   ex_d.op_a = fwd_data_i[0];
    endcase

    ex_d.op_b = (dec_i.op_b_sel == OP_B_IMM) ? dec_i.imm : fwd_data_i[1];

    // Branch target for EX, otherwise store data
    ex_d.op_c = dec_i.is_branch ? jump_target_i : fwd_data_i[1];

    // Bubble when nothing is accepted
    if (!accept) begin
      ex_d.valid     = 1'b0;
      ex_d.illegal   = 1'b0;
      ex_d.alu_op    = ALU_SLTU;
      ex_d.rd_we     = 1'b0;
      ex_d.mem_req   = 1'b0;
      ex_d.mem_we    = 1'b0;
      ex_d.is_load   = 1'b0;
      ex_d.is_branch = 1'b0;
    end
  end

  ////////////////////
  // ID/EX register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_q        <= '0;
      ex_q.alu_op <= ALU_SLTU;
    end else begin
      ex_q <= ex_d;
    end
  end

  assign ex_o = ex_q;

endmodule

// File: design/id_pkg.sv
package id_pkg;

  ////////////////////
  // Widths and field positions
  ////////////////////

  localparam int XLEN           = 32;
  localparam int NUM_REGS       = 32;
  localparam int REG_ADDR_W     = $clog2(NUM_REGS);
  localparam int NUM_READ_PORTS = 2;

  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int RD_LSB     = 7;
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_W   = 7;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  ////////////////////
  // Encodings
  ////////////////////

  // Major opcodes of the kept RV32I subset
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef enum logic [1:0] {
    OP_A_REG,
    OP_A_PC,
    OP_A_ZERO
  } op_a_sel_e;

  typedef enum logic [0:0] {
    OP_B_REG,
    OP_B_IMM
  } op_b_sel_e;

  ////////////////////
  // Stage bundles
  ////////////////////

  typedef struct packed {
    reg_addr_t [NUM_READ_PORTS-1:0] rs_addr;
    logic [NUM_READ_PORTS-1:0]      rs_used;
    reg_addr_t                      rd;
    logic                           rd_we;
    alu_op_e                        alu_op;
    op_a_sel_e                      op_a_sel;
    op_b_sel_e                      op_b_sel;
    word_t                          imm;
    logic                           mem_req;
    logic                           mem_we;
    logic                           is_load;
    logic                           is_branch;
    logic                           illegal;
  } decode_t;

  // One forwarding source, also used as the register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t waddr;
    word_t     wdata;
    logic      is_load;
  } fwd_src_t;

  typedef struct packed {
    logic      valid;
    logic      illegal;
    alu_op_e   alu_op;
    word_t     op_a;
    word_t     op_b;
    word_t     op_c;
    reg_addr_t rd;
    logic      rd_we;
    logic      mem_req;
    logic      mem_we;
    logic      is_load;
    logic      is_branch;
    word_t     pc;
  } id_ex_t;

endpackage

// File: design/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid_i,
  input  id_pkg::word_t    instr_i,
  input  id_pkg::word_t    pc_i,
  input  id_pkg::fwd_src_t ex_fwd_i,
  input  id_pkg::fwd_src_t wb_fwd_i,
  output logic             id_ready_o,
  output id_pkg::word_t    jump_target_o,
  output id_pkg::id_ex_t   ex_o
);
  import id_pkg::*;

  decode_t                          dec;
  word_t [NUM_READ_PORTS-1:0]       rf_rdata;
  word_t [NUM_READ_PORTS-1:0]       fwd_data;
  logic  [NUM_READ_PORTS-1:0]       load_hazard;

  instr_decoder u_decoder (
    .instr_i       (instr_i),
    .pc_i          (pc_i),
    .rs1_raw_i     (rf_rdata[0]),
    .dec_o         (dec),
    .jump_target_o (jump_target_o)
  );

  // Writeback result is also the write port
  register_file u_regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .raddr_i (dec.rs_addr),
    .rdata_o (rf_rdata),
    .wr_i    (wb_fwd_i)
  );

  // Lane 0 serves rs1, lane 1 serves rs2
  for (genvar k = 0; k < NUM_READ_PORTS; k++) begin : g_lane
    operand_lane u_lane (
      .rs_addr_i     (dec.rs_addr[k]),
      .rs_used_i     (dec.rs_used[k]),
      .rf_data_i     (rf_rdata[k]),
      .ex_fwd_i      (ex_fwd_i),
      .wb_fwd_i      (wb_fwd_i),
      .fwd_data_o    (fwd_data[k]),
      .load_hazard_o (load_hazard[k])
    );
  end

  id_ex_pipe u_pipe (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .pc_i          (pc_i),
    .dec_i         (dec),
    .jump_target_i (jump_target_o),
    .fwd_data_i    (fwd_data),
    .load_hazard_i (load_hazard),
    .id_ready_o    (id_ready_o),
    .ex_o          (ex_o)
  );

endmodule

// File: design/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
  input  id_pkg::word_t   instr_i,
  input  id_pkg::word_t   pc_i,
  input  id_pkg::word_t   rs1_raw_i,
  output id_pkg::decode_t dec_o,
  output id_pkg::word_t   jump_target_o
);
  import id_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  decode_t    dec;

  // Shared by OP and OP-IMM; alt is funct7 bit 5
  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = opcode_e'(instr_i[OPCODE_LSB +: OPCODE_W]);
  assign funct3 = instr_i[14:12];

  ////////////////////
  // Immediates
  ////////////////////

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  ////////////////////
  // Control decode
  ////////////////////

  always_comb begin
    dec            = '0;
    dec.rs_addr[0] = instr_i[RS1_LSB +: REG_ADDR_W];
    dec.rs_addr[1] = instr_i[RS2_LSB +: REG_ADDR_W];
    dec.rd         = instr_i[RD_LSB +: REG_ADDR_W];
    dec.alu_op     = ALU_ADD;
    dec.op_a_sel   = OP_A_REG;
    dec.op_b_sel   = OP_B_IMM;
    dec.imm        = imm_i;
    case (opcode)
      OPC_LUI: begin
        dec.rd_we    = 1'b1;
        dec.op_a_sel = OP_A_ZERO;
        dec.imm      = imm_u;
      end
      OPC_AUIPC: begin
        dec.rd_we    = 1'b1;
        dec.op_a_sel = OP_A_PC;
        dec.imm      = imm_u;
      end
      // Link value is PC + 4
      OPC_JAL, OPC_JALR: begin
        dec.rd_we      = 1'b1;
        dec.op_a_sel   = OP_A_PC;
        dec.imm        = 32'd4;
        dec.rs_used[0] = (opcode == OPC_JALR);
      end
      OPC_BRANCH: begin
        dec.is_branch = 1'b1;
        dec.rs_used   = 2'b11;
        dec.op_b_sel  = OP_B_REG;
        dec.imm       = imm_b;
        case (funct3[2:1])
          2'b10:   dec.alu_op = ALU_SLT;
          2'b11:   dec.alu_op = ALU_SLTU;
          default: dec.alu_op = ALU_SUB;
        endcase
      end
      OPC_LOAD: begin
        dec.rd_we      = 1'b1;
        dec.mem_req    = 1'b1;
        dec.is_load    = 1'b1;
        dec.rs_used[0] = 1'b1;
      end
      OPC_STORE: begin
        dec.mem_req = 1'b1;
        dec.mem_we  = 1'b1;
        dec.rs_used = 2'b11;
        dec.imm     = imm_s;
      end
      OPC_OP_IMM: begin
        dec.rd_we      = 1'b1;
        dec.rs_used[0] = 1'b1;
        // No SUBI, so bit 30 only matters for shifts
        dec.alu_op     = alu_from_funct3(funct3, instr_i[30] && funct3 == 3'b101);
      end
      OPC_OP: begin
        dec.rd_we    = 1'b1;
        dec.rs_used  = 2'b11;
        dec.op_b_sel = OP_B_REG;
        dec.alu_op   = alu_from_funct3(funct3, instr_i[30]);
      end
      default: begin
        dec.illegal = 1'b1;
      end
    endcase
  end

  assign dec_o = dec;

  // JALR takes rs1 straight from the register file, no forwarding
  always_comb begin
    case (opcode)
      OPC_JAL:    jump_target_o = pc_i + imm_j;
      OPC_BRANCH: jump_target_o = pc_i + imm_b;
      default:    jump_target_o = rs1_raw_i + imm_i;
    endcase
  end

endmodule

// File: design/operand_lane.sv
`timescale 1ns/1ps

module operand_lane (
  input  id_pkg::reg_addr_t rs_addr_i,
  input  logic              rs_used_i,
  input  id_pkg::word_t     rf_data_i,
  input  id_pkg::fwd_src_t  ex_fwd_i,
  input  id_pkg::fwd_src_t  wb_fwd_i,
  output id_pkg::word_t     fwd_data_o,
  output logic              load_hazard_o
);

  logic rs_live;
  logic ex_match;
  logic wb_match;

  // x0 is never forwarded
  assign rs_live  = rs_used_i && (rs_addr_i != '0);

  assign ex_match = rs_live && ex_fwd_i.we && (ex_fwd_i.waddr == rs_addr_i);
  assign wb_match = rs_live && wb_fwd_i.we && (wb_fwd_i.waddr == rs_addr_i);

  ////////////////////
  // Forwarding mux
  ////////////////////

  // Younger result in EX wins over WB
  always_comb begin
    if (ex_match) begin
      fwd_data_o = ex_fwd_i.wdata;
    end else if (wb_match) begin
      fwd_data_o = wb_fwd_i.wdata;
    end else begin
      fwd_data_o = rf_data_i;
    end
  end

  // Load data arrives too late for EX forwarding
  assign load_hazard_o = ex_match && ex_fwd_i.is_load;

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  id_pkg::reg_addr_t [id_pkg::NUM_READ_PORTS-1:0] raddr_i,
  output id_pkg::word_t     [id_pkg::NUM_READ_PORTS-1:0] rdata_o,
  input  id_pkg::fwd_src_t                              wr_i
);
  import id_pkg::*;

  // x0 has no storage
  word_t regs [NUM_REGS-1:1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_i.we && wr_i.waddr != '0) begin
      regs[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Combinational reads, one per operand lane
  for (genvar p = 0; p < NUM_READ_PORTS; p++) begin : g_rd
    assign rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
  end

endmodule

// File: dv/id_checker.sv
`timescale 1ns/1ps

module id_checker (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             instr_valid_i,
  input  id_pkg::word_t    instr_i,
  input  id_pkg::word_t    pc_i,
  input  id_pkg::fwd_src_t ex_fwd_i,
  input  id_pkg::fwd_src_t wb_fwd_i,
  input  logic             id_ready_i,
  input  id_pkg::word_t    jump_target_i,
  input  id_pkg::id_ex_t   ex_i,
  output int               errors_o,
  output int               checks_o
);
  import id_pkg::*;

  word_t  shadow [NUM_REGS];
  id_ex_t exp_ex;
  logic   exp_full;
  logic   seen_reset = 1'b0;
  int     err_cnt = 0;
  int     chk_cnt = 0;

  assign errors_o = err_cnt;
  assign checks_o = chk_cnt;

  task automatic expect_word(input string what, input word_t got, input word_t want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic expect_bit(input string what, input logic got, input logic want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, want);
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  function automatic alu_op_e expected_alu(input word_t ins);
    logic [6:0] opc;
    logic [2:0] f3;
    opc = ins[6:0];
    f3  = ins[14:12];
    if (opc == OPC_BRANCH) begin
      return (f3[2:1] == 2'b10) ? ALU_SLT : (f3[2:1] == 2'b11) ? ALU_SLTU : ALU_SUB;
    end
    if (opc != OPC_OP && opc != OPC_OP_IMM) begin
      return ALU_ADD;
    end
    case (f3)
      3'd0:    return (opc == OPC_OP && ins[30]) ? ALU_SUB : ALU_ADD;
      3'd1:    return ALU_SLL;
      3'd2:    return ALU_SLT;
      3'd3:    return ALU_SLTU;
      3'd4:    return ALU_XOR;
      3'd5:    return ins[30] ? ALU_SRA : ALU_SRL;
      3'd6:    return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  // EX first, then WB, then the shadow registers
  function automatic word_t pick_source(input reg_addr_t rs, input logic used);
    if (used && rs != '0 && ex_fwd_i.we && ex_fwd_i.waddr == rs) begin
      return ex_fwd_i.wdata;
    end
    if (used && rs != '0 && wb_fwd_i.we && wb_fwd_i.waddr == rs) begin
      return wb_fwd_i.wdata;
    end
    return shadow[rs];
  endfunction

  function automatic logic load_stall(input reg_addr_t rs, input logic used);
    return used && rs != '0 && ex_fwd_i.we && ex_fwd_i.is_load && ex_fwd_i.waddr == rs;
  endfunction

  task automatic compare_ex();
    expect_bit("ex_o.valid", ex_i.valid, exp_ex.valid);
    expect_bit("ex_o.rd_we", ex_i.rd_we, exp_ex.rd_we);
    expect_bit("ex_o.mem_req", ex_i.mem_req, exp_ex.mem_req);
    expect_bit("ex_o.mem_we", ex_i.mem_we, exp_ex.mem_we);
    expect_bit("ex_o.is_branch", ex_i.is_branch, exp_ex.is_branch);
    if (!exp_ex.valid) begin
      expect_word("bubble alu_op", word_t'(ex_i.alu_op), word_t'(exp_ex.alu_op));
    end else begin
      expect_bit("ex_o.illegal", ex_i.illegal, exp_ex.illegal);
      expect_bit("ex_o.is_load", ex_i.is_load, exp_ex.is_load);
    end
    if (exp_full) begin
      expect_word("ex_o.alu_op", word_t'(ex_i.alu_op), word_t'(exp_ex.alu_op));
      expect_word("ex_o.op_a", ex_i.op_a, exp_ex.op_a);
      expect_word("ex_o.op_b", ex_i.op_b, exp_ex.op_b);
      expect_word("ex_o.op_c", ex_i.op_c, exp_ex.op_c);
      expect_word("ex_o.rd", word_t'(ex_i.rd), word_t'(exp_ex.rd));
      expect_word("ex_o.pc", ex_i.pc, exp_ex.pc);
    end
  endtask

  task automatic predict_cycle();
    logic [6:0] opc;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       use1;
    logic       use2;
    logic       ready;
    word_t      imm_i;
    word_t      imm_b;
    word_t      src1;
    word_t      src2;
    word_t      target;
    id_ex_t     nxt;
    opc   = instr_i[6:0];
    rs1   = instr_i[19:15];
    rs2   = instr_i[24:20];
    use1  = opc inside {OPC_JALR, OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP};
    use2  = opc inside {OPC_BRANCH, OPC_STORE, OPC_OP};
    imm_i = $signed(instr_i) >>> 20;
    imm_b = {imm_i[31:12], instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
    src1  = pick_source(rs1, use1);
    src2  = pick_source(rs2, use2);
    ready = !(load_stall(rs1, use1) || load_stall(rs2, use2));
    case (opc)
      OPC_JAL:    target = pc_i + {imm_i[31:20], instr_i[19:12], instr_i[20],
                                   instr_i[30:21], 1'b0};
      OPC_BRANCH: target = pc_i + imm_b;
      default:    target = shadow[rs1] + imm_i;
    endcase
    expect_bit("id_ready_o", id_ready_i, ready);
    expect_word("jump_target_o", jump_target_i, target);

    nxt        = '0;
    nxt.alu_op = ALU_SLTU;
    exp_full   = 1'b0;
    if (instr_valid_i && ready) begin
      exp_full   = 1'b1;
      nxt.valid  = 1'b1;
      nxt.pc     = pc_i;
      nxt.rd     = instr_i[11:7];
      nxt.alu_op = expected_alu(instr_i);
      nxt.op_a   = src1;
      nxt.op_b   = imm_i;
      nxt.op_c   = src2;
      case (opc)
        OPC_LUI: begin
          nxt.rd_we = 1'b1;
          nxt.op_a  = '0;
          nxt.op_b  = {instr_i[31:12], 12'h000};
        end
        OPC_AUIPC: begin
          nxt.rd_we = 1'b1;
          nxt.op_a  = pc_i;
          nxt.op_b  = {instr_i[31:12], 12'h000};
        end
        OPC_JAL, OPC_JALR: begin
          nxt.rd_we = 1'b1;
          nxt.op_a  = pc_i;
          nxt.op_b  = 32'd4;
        end
        OPC_BRANCH: begin
          nxt.is_branch = 1'b1;
          nxt.op_b      = src2;
          nxt.op_c      = target;
        end
        OPC_LOAD: begin
          nxt.rd_we   = 1'b1;
          nxt.mem_req = 1'b1;
          nxt.is_load = 1'b1;
        end
        OPC_STORE: begin
          nxt.mem_req = 1'b1;
          nxt.mem_we  = 1'b1;
          nxt.op_b    = {imm_i[31:5], instr_i[11:7]};
        end
        OPC_OP_IMM: begin
          nxt.rd_we = 1'b1;
        end
        OPC_OP: begin
          nxt.rd_we = 1'b1;
          nxt.op_b  = src2;
        end
        default: begin
          nxt.illegal = 1'b1;
          exp_full    = 1'b0;
        end
      endcase
    end
    exp_ex = nxt;

    // Writeback lands at this edge, after the reads above
    if (wb_fwd_i.we && wb_fwd_i.waddr != '0) begin
      shadow[wb_fwd_i.waddr] = wb_fwd_i.wdata;
    end
  endtask

  always @(posedge clk) begin
    if (seen_reset) begin
      compare_ex();
    end
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        shadow[i] = '0;
      end
      exp_ex        = '0;
      exp_ex.alu_op = ALU_SLTU;
      exp_full      = 1'b0;
      seen_reset    = 1'b1;
    end else begin
      predict_cycle();
    end
  end

endmodule

// File: dv/id_properties.sv
`timescale 1ns/1ps

module id_properties (
  input logic           clk,
  input logic           rst_n,
  input logic           id_ready_i,
  input id_pkg::id_ex_t ex_i
);

  int fail_cnt = 0;

  // A stalled cycle leaves a bubble behind it
  a_bubble_after_stall : assert property (
    @(posedge clk) disable iff (!rst_n) !id_ready_i |=> !ex_i.valid
  ) else begin
    $error("ex_o valid after a cycle with id_ready_o low");
    fail_cnt++;
  end

  a_no_enable_in_bubble : assert property (
    @(posedge clk) !ex_i.valid |-> !(ex_i.rd_we || ex_i.mem_req || ex_i.mem_we || ex_i.is_branch)
  ) else begin
    $error("enable set in ex_o while valid is low");
    fail_cnt++;
  end

  a_idle_after_reset : assert property (
    @(posedge clk) $rose(rst_n) |-> !ex_i.valid
  ) else begin
    $error("ex_o valid right after reset release");
    fail_cnt++;
  end

endmodule

// File: dv/tb_top.sv
`timescale 1ns/1ps

module tb_top;
  import id_pkg::*;

  localparam int NUM_INSTR  = 2000;
  localparam int MAX_CYCLES = 2 * NUM_INSTR;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  word_t       instr;
  word_t       pc;
  fwd_src_t    ex_fwd;
  fwd_src_t    wb_fwd;
  logic        id_ready;
  word_t       jump_target;
  id_ex_t      ex_out;
  logic [31:0] rng_state = 32'he8de;
  int          issued = 0;
  int          cycles = 0;
  int          chk_errors;
  int          chk_count;
  int          total_errors;

  id_stage dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .ex_fwd_i      (ex_fwd),
    .wb_fwd_i      (wb_fwd),
    .id_ready_o    (id_ready),
    .jump_target_o (jump_target),
    .ex_o          (ex_out)
  );

  id_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .pc_i          (pc),
    .ex_fwd_i      (ex_fwd),
    .wb_fwd_i      (wb_fwd),
    .id_ready_i    (id_ready),
    .jump_target_i (jump_target),
    .ex_i          (ex_out),
    .errors_o      (chk_errors),
    .checks_o      (chk_count)
  );

  bind id_ex_pipe id_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .id_ready_i (id_ready_o),
    .ex_i       (ex_o)
  );

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [6:0] pick_opcode(input logic [3:0] sel);
    case (sel)
      4'd0:                return OPC_LUI;
      4'd1:                return OPC_AUIPC;
      4'd2:                return OPC_JAL;
      4'd3:                return OPC_JALR;
      4'd4, 4'd5:          return OPC_BRANCH;
      4'd6, 4'd7:          return OPC_LOAD;
      4'd8, 4'd9:          return OPC_STORE;
      4'd10, 4'd11:        return OPC_OP_IMM;
      4'd12, 4'd13, 4'd14: return OPC_OP;
      // SYSTEM, not decoded by this stage
      default:             return 7'b1110011;
    endcase
  endfunction

  function automatic fwd_src_t random_source();
    logic [31:0] r;
    fwd_src_t    s;
    r         = next_random();
    s.we      = r[0] | r[1];
    s.is_load = r[2] & r[3];
    // Half the time aim at a source of the current instruction
    if (r[4]) begin
      s.waddr = r[5] ? instr[19:15] : instr[24:20];
    end else begin
      s.waddr = r[12:8];
    end
    s.wdata = next_random();
    return s;
  endfunction

  task automatic drive_cycle();
    logic [31:0] r;
    if (instr_valid && id_ready) begin
      issued++;
      pc = pc + 32'd4;
    end
    // Stalled instruction stays on the inputs
    if (!instr_valid || id_ready) begin
      r           = next_random();
      instr       = next_random();
      instr[6:0]  = pick_opcode(r[3:0]);
      instr_valid = (r[6:4] != 3'd0);
    end
    ex_fwd = random_source();
    wb_fwd = random_source();
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst_n       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    pc          = 32'h0000_1000;
    ex_fwd      = '0;
    wb_fwd      = '0;
    #1 rst_n = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (issued < NUM_INSTR) begin
      @(negedge clk);
      drive_cycle();
    end
    // Drain so the last instruction is compared on ex_o
    repeat (2) @(posedge clk);
    @(negedge clk);
    total_errors = chk_errors + dut_i.u_pipe.u_props.fail_cnt;
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
             chk_count, chk_errors, dut_i.u_pipe.u_props.fail_cnt);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout: %0d of %0d instructions issued in %0d cycles",
               issued, NUM_INSTR, cycles);
      $display("tests failed");
      $finish;
    end
  end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_top -f vlog.f \
  && ./obj_dir/Vtb_top +verilator+error+limit+1000 \
  | tee /dev/stderr \
  | grep -x "all tests passed" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// File: vlog.f
design/id_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/operand_lane.sv
design/id_ex_pipe.sv
design/id_stage.sv
dv/id_properties.sv
dv/id_checker.sv
dv/tb_top.sv
